/* project.f */
common/noc_pkg.sv
vc_buffer/vc_flit_buffer.sv
vc_buffer/vc_route_table.sv
verilog/lookahead_xy_router.sv
verilog/flit_rewriter.sv
verilog/input_port.sv
tests/tb_clock.sv
tests/tb_input_port.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the input port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_input_port \
	-f project.f -o tb_input_port
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_input_port)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1

/* tests/tb_input_port.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_input_port import noc_pkg::*; ();

	localparam int V           = V_DEFAULT;
	localparam int B           = 4;
	localparam int NX          = 4;
	localparam int NY          = 4;
	localparam int N_PKTS      = 60;	// packets in the interleaved test
	localparam int CYCLE_LIMIT = 160 + N_PKTS * B * 16;

	logic                clk;
	logic                reset;
	logic [COORD_W-1:0]  current_x;
	logic [COORD_W-1:0]  current_y;
	flit_t               flit_in;
	logic                flit_in_we;
	logic [V-1:0]        ivc_grant;
	logic [V-1:0][V-1:0] assigned_ovc;
	logic [V-1:0]        release_ivc;
	vc_info_t [V-1:0]    vc_info;
	flit_t               flit_out;
	logic                flit_out_valid;

	flit_t        mq [V][$];	// expected contents of each vc queue
	logic [V-1:0] m_active;
	logic [V-1:0] exp_req;
	logic [V-1:0] exp_tail;
	logic [V-1:0] dest_known;
	logic [V-1:0] lk_known;
	logic [V-1:0] lk_pend;	// header written one edge ago
	port_e        lk_pend_val;
	port_e        m_dest [V];
	port_e        m_lk [V];
	flit_t        exp_flit;
	logic         exp_valid;
	int           err_count = 0;
	int           test_count = 0;
	int           test_errs_start = 0;
	int           cycle_count = 0;

	tb_clock #(.PERIOD(4.0), .RESET_CYCLES(4)) tb_clock_i (.*);

	input_port #(.V(V), .B(B), .NX(NX), .NY(NY)) input_port_i (.*);

	// dimension order with x before y
	function automatic port_e xy_step(input int fx, input int fy, input int tx, input int ty);
		if (tx != fx)
			return (tx > fx) ? EAST : WEST;
		if (ty != fy)
			return (ty > fy) ? NORTH : SOUTH;
		return LOCAL;
	endfunction

	function automatic port_e lookahead_ref(input hdr_fields_t h);
		int nx;
		int ny;
		nx = int'(current_x) + ((h.dest_port == EAST) ? 1 : 0) - ((h.dest_port == WEST) ? 1 : 0);
		ny = int'(current_y) + ((h.dest_port == NORTH) ? 1 : 0) - ((h.dest_port == SOUTH) ? 1 : 0);
		return xy_step(nx, ny, int'(h.x_dst), int'(h.y_dst));
	endfunction

	function automatic flit_t rewrite_ref(input flit_t f, input int k);
		flit_t r;
		r    = f;
		r.vc = assigned_ovc[k];
		if (f.hdr)
			r.payload.hdr.dest_port = lookahead_ref(f.payload.hdr);
		return r;
	endfunction

	task automatic value_error(input string sig, input logic [63:0] expv, input logic [63:0] gotv);
		$display("ERR %0t %s exp %0h got %0h", $time, sig, expv, gotv);
		err_count++;
	endtask

	// reference model updated at every edge like the DUT
	always @(posedge clk or posedge reset) begin
		logic hdr_k;
		logic act_k;
		if (reset) begin
			for (int k = 0; k < V; k++)
				mq[k].delete();
			m_active   <= '0;
			exp_req    <= '0;
			exp_tail   <= '0;
			dest_known <= '0;
			lk_known   <= '0;
			lk_pend    <= '0;
			exp_valid  <= 1'b0;
		end else begin
			exp_valid   <= 1'b0;
			lk_pend     <= (flit_in_we && flit_in.hdr) ? flit_in.vc : '0;
			lk_pend_val <= lookahead_ref(flit_in.payload.hdr);
			for (int k = 0; k < V; k++) begin
				if (ivc_grant[k] && mq[k].size() != 0) begin
					exp_flit  <= rewrite_ref(mq[k].pop_front(), k);
					exp_valid <= 1'b1;
				end
				if (flit_in_we && flit_in.vc[k])
					mq[k].push_back(flit_in);
				hdr_k = flit_in_we && flit_in.hdr && flit_in.vc[k];
				act_k = (m_active[k] && !release_ivc[k]) || hdr_k;	// header wins over release
				m_active[k] <= act_k;
				exp_req[k]  <= act_k && (mq[k].size() != 0);
				exp_tail[k] <= (mq[k].size() != 0) ? mq[k][0].tail : 1'b0;
				if (hdr_k) begin
					m_dest[k]     <= flit_in.payload.hdr.dest_port;
					dest_known[k] <= 1'b1;
				end
				if (lk_pend[k]) begin
					m_lk[k]     <= lk_pend_val;
					lk_known[k] <= 1'b1;
				end
			end
		end
	end

	a_out_valid: assert property (@(posedge clk) disable iff (reset)
		flit_out_valid == exp_valid)
		else value_error("flit_out_valid", 64'($sampled(exp_valid)),
			64'($sampled(flit_out_valid)));

	a_out_flit: assert property (@(posedge clk) disable iff (reset)
		exp_valid |-> flit_out == exp_flit)
		else value_error("flit_out", 64'($sampled(exp_flit)), 64'($sampled(flit_out)));

	for (genvar k = 0; k < V; k++) begin : g_vc_check
		a_request: assert property (@(posedge clk) disable iff (reset)
			vc_info[k].request == exp_req[k])
			else value_error($sformatf("vc_info[%0d].request", k), 64'($sampled(exp_req[k])),
				64'($sampled(vc_info[k].request)));
		a_tail: assert property (@(posedge clk) disable iff (reset)
			vc_info[k].tail == exp_tail[k])
			else value_error($sformatf("vc_info[%0d].tail", k), 64'($sampled(exp_tail[k])),
				64'($sampled(vc_info[k].tail)));
		a_dest: assert property (@(posedge clk) disable iff (reset)
			dest_known[k] |-> vc_info[k].dest_port == m_dest[k])
			else value_error($sformatf("vc_info[%0d].dest_port", k), 64'($sampled(m_dest[k])),
				64'($sampled(vc_info[k].dest_port)));
		a_lk: assert property (@(posedge clk) disable iff (reset)
			lk_known[k] |-> vc_info[k].lk_port == m_lk[k])
			else value_error($sformatf("vc_info[%0d].lk_port", k), 64'($sampled(m_lk[k])),
				64'($sampled(vc_info[k].lk_port)));
	end

	task automatic put_flit(input int k, input logic is_hdr, input logic is_tail);
		flit_t f;
		f.payload.data = $urandom;
		f.hdr          = is_hdr;
		f.tail         = is_tail;
		f.vc           = V'(1) << k;
		if (is_hdr) begin
			f.payload.hdr.x_dst     = COORD_W'($urandom_range(NX - 1));
			f.payload.hdr.y_dst     = COORD_W'($urandom_range(NY - 1));
			f.payload.hdr.x_src     = current_x;
			f.payload.hdr.y_src     = current_y;
			f.payload.hdr.dest_port = xy_step(int'(current_x), int'(current_y),
				int'(f.payload.hdr.x_dst), int'(f.payload.hdr.y_dst));
		end
		flit_in    = f;
		flit_in_we = 1'b1;
	endtask

	task automatic set_ovc_map();
		for (int k = 0; k < V; k++)
			assigned_ovc[k] = V'(1) << $urandom_range(V - 1);
	endtask

	// upstream writer with credits plus a random switch until every packet has left
	task automatic run_traffic(input logic [V-1:0] vc_mask, input int n_pkts, input int min_len);
		int           started;
		int           done_pkts;
		int           k;
		int           g;
		int           left [V];
		logic [V-1:0] busy;
		logic [V-1:0] rel;
		started   = 0;
		done_pkts = 0;
		busy      = '0;
		rel       = '0;
		for (int i = 0; i < V; i++)
			left[i] = 0;
		while (done_pkts < n_pkts) begin
			@(negedge clk);
			flit_in_we  = 1'b0;
			ivc_grant   = '0;
			release_ivc = rel;
			busy        = busy & ~rel;
			rel         = '0;
			do
				k = $urandom_range(V - 1);
			while (!vc_mask[k]);
			if ($urandom_range(3) != 0) begin
				if (!busy[k] && started < n_pkts) begin
					left[k] = $urandom_range(B, min_len);
					busy[k] = 1'b1;
					started++;
					put_flit(k, 1'b1, 1'b0);
					left[k]--;
				end else if (left[k] > 0 && mq[k].size() < B) begin
					put_flit(k, 1'b0, left[k] == 1);
					left[k]--;
				end
			end
			g = $urandom_range(V - 1);
			if (vc_info[g].request && $urandom_range(1) == 1 && mq[g].size() != 0) begin
				ivc_grant[g] = 1'b1;
				if (mq[g][0].tail) begin
					rel[g] = 1'b1;	// packet done once the tail is popped
					done_pkts++;
				end
			end
		end
		@(negedge clk);
		flit_in_we  = 1'b0;
		ivc_grant   = '0;
		release_ivc = rel;
		@(negedge clk);
		release_ivc = '0;
		repeat (3) @(negedge clk);
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, err_count - test_errs_start);
		test_errs_start = err_count;
	endtask

	initial begin
		void'($urandom(28773));
		current_x    = COORD_W'(1);
		current_y    = COORD_W'(2);
		flit_in      = '0;
		flit_in_we   = 1'b0;
		ivc_grant    = '0;
		release_ivc  = '0;
		assigned_ovc = '0;
		set_ovc_map();
		@(negedge reset);
		repeat (3) @(negedge clk);
		finish_test("reset state");
		run_traffic(V'(2), 1, B);	// fills vc 1 to its depth
		finish_test("single packet");
		current_x = COORD_W'($urandom_range(NX - 1));
		current_y = COORD_W'($urandom_range(NY - 1));
		set_ovc_map();
		run_traffic(V'(2), 1, B);
		finish_test("new route after release");
		run_traffic('1, N_PKTS, 2);
		finish_test("interleaved traffic");
		$display("%0d tests run, %0d errors", test_count, err_count);
		if (err_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter real PERIOD       = 4.0,
	parameter int  RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;	// released away from the active edge
	end

endmodule

`default_nettype wire

/* verilog/input_port.sv */
`timescale 1ns/10ps
`default_nettype none

module input_port import noc_pkg::*; #(
	parameter int V  = 4,
	parameter int B  = 4,
	parameter int NX = 4,
	parameter int NY = 4
) (
	input  wire                      clk,
	input  wire                      reset,
	input  wire  [COORD_W-1:0]       current_x,
	input  wire  [COORD_W-1:0]       current_y,
	input  flit_t                    flit_in,
	input  wire                      flit_in_we,
	input  wire  [V-1:0]             ivc_grant,	// one-hot from the switch allocator
	input  wire  [V-1:0][V-1:0]      assigned_ovc,
	input  wire  [V-1:0]             release_ivc,
	output vc_info_t [V-1:0]         vc_info,
	output flit_t                    flit_out,
	output logic                     flit_out_valid
);

	flit_t          rd_flit;
	logic           rd_valid;
	logic [V-1:0]   vc_not_empty;
	logic [V-1:0]   head_tail;
	port_e          lk_port;

	// flit_t carries a fixed vc field
	if (V != V_DEFAULT) begin : g_v_check
		$error("input_port: V must equal noc_pkg::V_DEFAULT");
	end

	vc_flit_buffer #(
		.V(V),
		.B(B)
	) vc_flit_buffer_i (
		.clk          (clk),
		.reset        (reset),
		.wr_flit      (flit_in),
		.wr_en        (flit_in_we),
		.rd_vc        (ivc_grant),
		.rd_flit      (rd_flit),
		.rd_valid     (rd_valid),
		.vc_not_empty (vc_not_empty),
		.head_tail    (head_tail)
	);

	vc_route_table #(
		.V(V)
	) vc_route_table_i (
		.clk          (clk),
		.reset        (reset),
		.hdr_flit     (flit_in),
		.wr_en        (flit_in_we),
		.lk_port      (lk_port),
		.release_ivc  (release_ivc),
		.vc_not_empty (vc_not_empty),
		.head_tail    (head_tail),
		.vc_info      (vc_info)
	);

	// fed straight from the incoming flit, stored by the table a cycle later
	lookahead_xy_router #(
		.NX(NX),
		.NY(NY)
	) lookahead_xy_router_i (
		.clk       (clk),
		.reset     (reset),
		.current_x (current_x),
		.current_y (current_y),
		.dest_port (flit_in.payload.hdr.dest_port),
		.x_dst     (flit_in.payload.hdr.x_dst),
		.y_dst     (flit_in.payload.hdr.y_dst),
		.lk_port   (lk_port)
	);

	flit_rewriter #(
		.V(V)
	) flit_rewriter_i (
		.clk            (clk),
		.reset          (reset),
		.rd_flit        (rd_flit),
		.rd_valid       (rd_valid),
		.rd_vc          (ivc_grant),
		.assigned_ovc   (assigned_ovc),
		.vc_info        (vc_info),
		.flit_out       (flit_out),
		.flit_out_valid (flit_out_valid)
	);

endmodule

`default_nettype wire

/* verilog/flit_rewriter.sv */
`timescale 1ns/10ps
`default_nettype none

module flit_rewriter import noc_pkg::*; #(
	parameter int V = 4
) (
	input  wire                  clk,
	input  wire                  reset,
	input  flit_t                rd_flit,
	input  wire                  rd_valid,
	input  wire  [V-1:0]         rd_vc,	// grant, one cycle ahead of rd_flit
	input  wire  [V-1:0][V-1:0]  assigned_ovc,
	input  vc_info_t [V-1:0]     vc_info,
	output flit_t                flit_out,
	output logic                 flit_out_valid
);

	logic [V-1:0] rd_vc_d;
	logic [V-1:0] ovc;
	logic [2:0]   lk_bits;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rd_vc_d <= '0;
		else
			rd_vc_d <= rd_vc;
	end

	// one-hot select of the granted vc's ovc and look-ahead port
	always_comb begin
		ovc     = '0;
		lk_bits = '0;
		for (int i = 0; i < V; i++) begin
			if (rd_vc_d[i]) begin
				ovc     = ovc | assigned_ovc[i];
				lk_bits = lk_bits | vc_info[i].lk_port;
			end
		end
	end

	always_comb begin
		flit_out    = rd_flit;
		flit_out.vc = ovc;
		if (rd_flit.hdr)
			flit_out.payload.hdr.dest_port = port_e'(lk_bits);	// body payload untouched
	end

	assign flit_out_valid = rd_valid;

	// the switch must have assigned exactly one output vc before granting
	a_ovc_onehot: assert property (@(posedge clk) disable iff (reset)
		flit_out_valid |-> $onehot(flit_out.vc))
		else $error("flit_rewriter: granted vc has no single output vc");

endmodule

`default_nettype wire

/* verilog/lookahead_xy_router.sv */
`timescale 1ns/10ps
`default_nettype none

module lookahead_xy_router import noc_pkg::*; #(
	parameter int NX = 4,
	parameter int NY = 4
) (
	input  wire                clk,
	input  wire                reset,
	input  wire  [COORD_W-1:0] current_x,
	input  wire  [COORD_W-1:0] current_y,
	input  port_e              dest_port,	// port taken out of this router
	input  wire  [COORD_W-1:0] x_dst,
	input  wire  [COORD_W-1:0] y_dst,
	output port_e              lk_port
);

	logic [COORD_W-1:0] next_x;
	logic [COORD_W-1:0] next_y;
	port_e              route;

	// coordinates of the neighbor, held inside the mesh
	always_comb begin
		next_x = current_x;
		next_y = current_y;
		case (dest_port)
			EAST:    if (current_x < COORD_W'(NX - 1)) next_x = current_x + 1'b1;
			WEST:    if (current_x != '0) next_x = current_x - 1'b1;
			NORTH:   if (current_y < COORD_W'(NY - 1)) next_y = current_y + 1'b1;
			SOUTH:   if (current_y != '0) next_y = current_y - 1'b1;
			default: ;	// local, no hop
		endcase
	end

	// x first, then y
	always_comb begin
		if (x_dst > next_x)
			route = EAST;
		else if (x_dst < next_x)
			route = WEST;
		else if (y_dst > next_y)
			route = NORTH;
		else if (y_dst < next_y)
			route = SOUTH;
		else
			route = LOCAL;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			lk_port <= LOCAL;
		else
			lk_port <= route;
	end

endmodule

`default_nettype wire

/* vc_buffer/vc_route_table.sv */
`timescale 1ns/10ps
`default_nettype none

module vc_route_table import noc_pkg::*; #(
	parameter int V = 4
) (
	input  wire              clk,
	input  wire              reset,
	input  flit_t            hdr_flit,
	input  wire              wr_en,
	input  port_e            lk_port,	// registered router result
	input  wire  [V-1:0]     release_ivc,
	input  wire  [V-1:0]     vc_not_empty,
	input  wire  [V-1:0]     head_tail,
	output vc_info_t [V-1:0] vc_info
);

	logic [V-1:0] hdr_wr;
	logic [V-1:0] body_wr;
	logic [V-1:0] hdr_wr_d;	// lines up with the router output
	logic [V-1:0] active;
	port_e        dest_q [V];
	port_e        lk_q [V];

	assign hdr_wr  = (wr_en && hdr_flit.hdr) ? hdr_flit.vc : '0;
	assign body_wr = (wr_en && !hdr_flit.hdr) ? hdr_flit.vc : '0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hdr_wr_d <= '0;
			active   <= '0;
		end else begin
			hdr_wr_d <= hdr_wr;
			active   <= (active & ~release_ivc) | hdr_wr;	// new header wins over release
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < V; i++) begin
			if (hdr_wr[i])
				dest_q[i] <= hdr_flit.payload.hdr.dest_port;
			if (hdr_wr_d[i])
				lk_q[i] <= lk_port;
		end
	end

	always_comb begin
		for (int i = 0; i < V; i++) begin
			vc_info[i].request   = vc_not_empty[i] & active[i];
			vc_info[i].tail      = vc_not_empty[i] & head_tail[i];
			vc_info[i].dest_port = dest_q[i];
			vc_info[i].lk_port   = lk_q[i];
		end
	end

	// one packet per vc until the switch releases it
	a_hdr_into_idle: assert property (@(posedge clk) disable iff (reset)
		(hdr_wr & active & ~release_ivc) == '0)
		else $error("vc_route_table: header received in an active vc");

	a_body_into_active: assert property (@(posedge clk) disable iff (reset)
		(body_wr & ~active) == '0)
		else $error("vc_route_table: body or tail flit received in an idle vc");

endmodule

`default_nettype wire

/* vc_buffer/vc_flit_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module vc_flit_buffer import noc_pkg::*; #(
	parameter int V = 4,
	parameter int B = 4
) (
	input  wire          clk,
	input  wire          reset,
	input  flit_t        wr_flit,
	input  wire          wr_en,
	input  wire  [V-1:0] rd_vc,	// one-hot pop
	output flit_t        rd_flit,
	output logic         rd_valid,
	output logic [V-1:0] vc_not_empty,
	output logic [V-1:0] head_tail
);

	localparam int PTR_W = (B > 1) ? $clog2(B) : 1;
	localparam int CNT_W = $clog2(B + 1);
	localparam int IDX_W = (V > 1) ? $clog2(V) : 1;

	flit_t            mem [V][B];	// one circular queue per vc
	logic [PTR_W-1:0] wr_ptr [V];
	logic [PTR_W-1:0] rd_ptr [V];
	logic [CNT_W-1:0] count [V];
	logic [V-1:0]     wr_sel;
	logic [V-1:0]     vc_full;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	function automatic logic [IDX_W-1:0] onehot_to_idx(input logic [V-1:0] oh);
		logic [IDX_W-1:0] idx;
		idx = '0;
		for (int i = 0; i < V; i++) begin
			if (oh[i])
				idx = IDX_W'(i);
		end
		return idx;
	endfunction

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(B - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign wr_sel = wr_en ? wr_flit.vc : '0;	// write vc taken from the flit itself
	assign wr_idx = onehot_to_idx(wr_flit.vc);
	assign rd_idx = onehot_to_idx(rd_vc);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_idx][wr_ptr[wr_idx]] <= wr_flit;
	end

	always_ff @(posedge clk) begin
		if (|rd_vc)
			rd_flit <= mem[rd_idx][rd_ptr[rd_idx]];	// one cycle read latency
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= |rd_vc;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < V; i++) begin
				wr_ptr[i] <= '0;
				rd_ptr[i] <= '0;
				count[i]  <= '0;
			end
		end else begin
			for (int i = 0; i < V; i++) begin
				if (wr_sel[i])
					wr_ptr[i] <= next_ptr(wr_ptr[i]);
				if (rd_vc[i])
					rd_ptr[i] <= next_ptr(rd_ptr[i]);
				case ({wr_sel[i], rd_vc[i]})
					2'b10:   count[i] <= count[i] + 1'b1;
					2'b01:   count[i] <= count[i] - 1'b1;
					default: ;	// push and pop together keep the level
				endcase
			end
		end
	end

	always_comb begin
		for (int i = 0; i < V; i++) begin
			vc_not_empty[i] = (count[i] != '0);
			vc_full[i]      = (count[i] == CNT_W'(B));
			head_tail[i]    = mem[i][rd_ptr[i]].tail;	// stale when empty
		end
	end

	// credit flow upstream must keep every queue from overflowing
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> ((wr_flit.vc & vc_full) == '0))
		else $error("vc_flit_buffer: write to a full vc");

	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		(rd_vc & ~vc_not_empty) == '0)
		else $error("vc_flit_buffer: grant to an empty vc");

	a_rd_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(rd_vc))
		else $error("vc_flit_buffer: grant is not one-hot");

endmodule

`default_nettype wire

/* common/noc_pkg.sv */
`default_nettype none

package noc_pkg;

	localparam int COORD_W   = 4;	// x/y field width in a header
	localparam int PAYLOAD_W = 32;
	localparam int V_DEFAULT = 4;	// vc field width carried by flit_t

	// router port codes, east is x+1 and north is y+1
	typedef enum logic [2:0] {
		LOCAL = 3'd0,
		EAST  = 3'd1,
		NORTH = 3'd2,
		WEST  = 3'd3,
		SOUTH = 3'd4
	} port_e;

	// header reading of the payload
	typedef struct packed {
		logic [12:0]        pad;
		port_e              dest_port;	// port to take in the receiving router
		logic [COORD_W-1:0] x_dst;
		logic [COORD_W-1:0] y_dst;
		logic [COORD_W-1:0] x_src;
		logic [COORD_W-1:0] y_src;
	} hdr_fields_t;

	// the hdr flag of the flit picks the reading
	typedef union packed {
		hdr_fields_t          hdr;
		logic [PAYLOAD_W-1:0] data;
	} payload_u;

	typedef struct packed {
		logic                 hdr;
		logic                 tail;
		logic [V_DEFAULT-1:0] vc;	// one-hot
		payload_u             payload;
	} flit_t;

	// status of one input vc as seen by the allocators
	typedef struct packed {
		logic  request;	// flit waiting
		logic  tail;	// head flit is a tail
		port_e dest_port;
		port_e lk_port;	// port of the next router
	} vc_info_t;

endpackage

`default_nettype wire
